//--- Bender.yml
package:
  name: eeprom_rw

sources:
  - files:
      - source/eeprom_pkg.sv
      - source/eeprom_ctrl.sv
      - source/byte_shifter.sv
      - source/bit_slot_gen.sv
      - source/eeprom_rw_top.sv
  - target: test
    files:
      - test/eeprom_props.sv
      - test/eeprom_model.sv
      - test/eeprom_checker.sv
      - test/tb_eeprom_rw.sv

//--- source/bit_slot_gen.sv
module bit_slot_gen (
    input  logic                  CLK,
    input  logic                  RESET,
    input  eeprom_pkg::slot_req_t slot_req,
    input  logic                  tx_bit,
    output logic                  slot_done,
    output logic                  sample_bit,
    output logic                  scl,
    inout  wire                   sda
);

    logic                     active;     // a slot is being played
    logic                     bus_idle;   // set by stop, cleared by start
    eeprom_pkg::slot_kind_e   kind_q;
    eeprom_pkg::phase_t       phase;
    eeprom_pkg::quarter_cnt_t qcnt;
    logic                     sda_low;
    logic                     shape_low;
    logic                     shape_scl;
    logic                     last_low;
    logic                     quarter_end;

    assign quarter_end = (qcnt == eeprom_pkg::QUARTER_LAST);
    assign slot_done   = active && quarter_end && (phase == eeprom_pkg::PHASE_LAST);

    always_comb
    begin
        case (kind_q)
            eeprom_pkg::slot_start:
            begin
                shape_scl = (phase == 2'd1) || (phase == 2'd2);
                shape_low = phase[1];   // falls in the middle of SCL high
            end
            eeprom_pkg::slot_stop:
            begin
                shape_scl = (phase != 2'd0);
                shape_low = ~phase[1];  // rises in the middle of SCL high
            end
            default:
            begin
                shape_scl = (phase == 2'd1) || (phase == 2'd2);
                shape_low = ~tx_bit;
            end
        endcase
    end

    // between slots scl rests low, after a stop it rests high
    assign scl     = active ? shape_scl : bus_idle;
    assign sda_low = active ? shape_low : last_low;
    assign sda     = sda_low ? 1'b0 : 1'bz;   // open drain

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            bus_idle <= 1'b1;
            kind_q   <= eeprom_pkg::slot_stop;
            phase    <= '0;
            qcnt     <= '0;
            last_low <= 1'b0;
        end
        else if (!active)
        begin
            if (slot_req.go)
            begin
                active <= 1'b1;
                kind_q <= slot_req.kind;
                phase  <= '0;
                qcnt   <= '0;
                if (slot_req.kind == eeprom_pkg::slot_start)
                    bus_idle <= 1'b0;
            end
        end
        else
        begin
            last_low <= shape_low;
            if (quarter_end)
            begin
                qcnt  <= '0;
                phase <= phase + 2'd1;
                if (phase == eeprom_pkg::PHASE_LAST)
                begin
                    active <= 1'b0;
                    if (kind_q == eeprom_pkg::slot_stop)
                        bus_idle <= 1'b1;
                end
            end
            else
                qcnt <= qcnt + 1'b1;
        end
    end

    // middle of scl high
    always_ff @(posedge CLK)
    begin
        if (active && quarter_end && (phase == 2'd1))
            sample_bit <= sda;
    end

endmodule

//--- source/byte_shifter.sv
module byte_shifter (
    input  logic                   CLK,
    input  logic                   RESET,
    input  eeprom_pkg::shift_cmd_t shift_cmd,
    input  logic                   data_kind,
    input  logic                   slot_done,
    input  logic                   sample_bit,
    output logic                   tx_bit,
    output logic                   byte_done,
    output logic                   ack_bit,
    output eeprom_pkg::mem_data_t  rx_byte
);

    // msb goes out first, samples come in at the bottom
    logic [8:0]           sr;
    eeprom_pkg::bit_idx_t bit_cnt;
    logic                 advance;

    assign advance   = data_kind & slot_done;
    assign byte_done = advance && (bit_cnt == eeprom_pkg::ACK_SLOT);

    assign tx_bit = sr[8];

    // after the ninth shift the data sits above the acknowledge
    assign rx_byte = sr[8:1];

    // the ninth sample is only shifted in at the end of byte_done
    assign ack_bit = byte_done ? sample_bit : sr[0];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            sr      <= '1;   // released
            bit_cnt <= '0;
        end
        else if (shift_cmd.load)
        begin
            if (shift_cmd.receive)
                sr <= {8'hff, shift_cmd.master_ack};   // listen for 8, then answer
            else
                sr <= {shift_cmd.load_byte, 1'b1};     // 9th slot left to the slave
            bit_cnt <= '0;
        end
        else if (advance)
        begin
            sr <= {sr[7:0], sample_bit};
            if (byte_done)
                bit_cnt <= '0;
            else
                bit_cnt <= bit_cnt + 4'd1;
        end
    end

endmodule

//--- source/eeprom_ctrl.sv
module eeprom_ctrl (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   wr,
    input  logic                   rd,
    input  eeprom_pkg::mem_addr_t  addr,
    input  eeprom_pkg::mem_data_t  data_in,
    input  logic                   slot_done,
    input  logic                   byte_done,
    input  logic                   ack_bit,
    input  eeprom_pkg::mem_data_t  rx_byte,
    output eeprom_pkg::slot_req_t  slot_req,
    output eeprom_pkg::shift_cmd_t shift_cmd,
    output logic                   data_kind,
    output logic                   done,
    output logic                   nack,
    output eeprom_pkg::mem_data_t  data_out
);

    eeprom_pkg::ctrl_state_e state;
    eeprom_pkg::mem_addr_t   addr_q;
    eeprom_pkg::mem_data_t   data_q;
    logic                    is_read;
    logic                    nack_q;

    function automatic eeprom_pkg::slot_req_t req(input eeprom_pkg::slot_kind_e kind);
        eeprom_pkg::slot_req_t r;
        r.kind = kind;
        r.go   = 1'b1;
        return r;
    endfunction

    // transmit load, ninth slot released for the slave's acknowledge
    function automatic eeprom_pkg::shift_cmd_t tx_load(input eeprom_pkg::mem_data_t b);
        eeprom_pkg::shift_cmd_t c;
        c.load       = 1'b1;
        c.load_byte  = b;
        c.receive    = 1'b0;
        c.master_ack = 1'b1;
        return c;
    endfunction

    // single random read, so the master always answers with NACK
    function automatic eeprom_pkg::shift_cmd_t rx_load();
        eeprom_pkg::shift_cmd_t c;
        c.load       = 1'b1;
        c.load_byte  = '0;
        c.receive    = 1'b1;
        c.master_ack = 1'b1;
        return c;
    endfunction

    function automatic eeprom_pkg::mem_data_t ctrl_byte(input logic rw);
        return {eeprom_pkg::DEVICE_TYPE, addr_q[10:8], rw};
    endfunction

    assign data_kind = (state == eeprom_pkg::st_ctrl_w) || (state == eeprom_pkg::st_addr)
                    || (state == eeprom_pkg::st_data_w) || (state == eeprom_pkg::st_ctrl_r)
                    || (state == eeprom_pkg::st_data_r);

    assign done = (state == eeprom_pkg::st_done);
    assign nack = done & nack_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::st_idle;
            slot_req  <= '0;
            shift_cmd <= '0;
            is_read   <= 1'b0;
            nack_q    <= 1'b0;
            data_out  <= '0;
        end
        else
        begin
            slot_req.go    <= 1'b0;   // strobes last one cycle
            shift_cmd.load <= 1'b0;

            // next bit of the current byte
            if (data_kind && slot_done && !byte_done)
                slot_req <= req(eeprom_pkg::slot_data);

            case (state)
                eeprom_pkg::st_idle:
                begin
                    if (wr || rd)
                    begin
                        addr_q   <= addr;
                        data_q   <= data_in;
                        is_read  <= ~wr;   // wr wins
                        nack_q   <= 1'b0;
                        slot_req <= req(eeprom_pkg::slot_start);
                        state    <= eeprom_pkg::st_start;
                    end
                end
                eeprom_pkg::st_start:
                begin
                    if (slot_done)
                    begin
                        slot_req  <= req(eeprom_pkg::slot_data);
                        shift_cmd <= tx_load(ctrl_byte(1'b0));
                        state     <= eeprom_pkg::st_ctrl_w;
                    end
                end
                eeprom_pkg::st_ctrl_w, eeprom_pkg::st_addr, eeprom_pkg::st_data_w,
                eeprom_pkg::st_ctrl_r:
                begin
                    if (byte_done && ack_bit)
                    begin
                        nack_q   <= 1'b1;   // slave did not answer, abort
                        slot_req <= req(eeprom_pkg::slot_stop);
                        state    <= eeprom_pkg::st_stop;
                    end
                    else if (byte_done)
                    begin
                        case (state)
                            eeprom_pkg::st_ctrl_w:
                            begin
                                slot_req  <= req(eeprom_pkg::slot_data);
                                shift_cmd <= tx_load(addr_q[7:0]);
                                state     <= eeprom_pkg::st_addr;
                            end
                            eeprom_pkg::st_addr:
                            begin
                                if (is_read)
                                begin
                                    slot_req <= req(eeprom_pkg::slot_start);
                                    state    <= eeprom_pkg::st_restart;
                                end
                                else
                                begin
                                    slot_req  <= req(eeprom_pkg::slot_data);
                                    shift_cmd <= tx_load(data_q);
                                    state     <= eeprom_pkg::st_data_w;
                                end
                            end
                            eeprom_pkg::st_ctrl_r:
                            begin
                                slot_req  <= req(eeprom_pkg::slot_data);
                                shift_cmd <= rx_load();
                                state     <= eeprom_pkg::st_data_r;
                            end
                            default:
                            begin
                                slot_req <= req(eeprom_pkg::slot_stop);
                                state    <= eeprom_pkg::st_stop;
                            end
                        endcase
                    end
                end
                eeprom_pkg::st_restart:
                begin
                    if (slot_done)
                    begin
                        slot_req  <= req(eeprom_pkg::slot_data);
                        shift_cmd <= tx_load(ctrl_byte(1'b1));
                        state     <= eeprom_pkg::st_ctrl_r;
                    end
                end
                eeprom_pkg::st_data_r:
                begin
                    if (byte_done)
                    begin
                        slot_req <= req(eeprom_pkg::slot_stop);
                        state    <= eeprom_pkg::st_stop;
                    end
                end
                eeprom_pkg::st_stop:
                begin
                    if (slot_done)
                    begin
                        if (is_read && !nack_q)
                            data_out <= rx_byte;
                        state <= eeprom_pkg::st_done;
                    end
                end
                default:
                    state <= eeprom_pkg::st_idle;   // st_done lasts one cycle
            endcase
        end
    end

endmodule

//--- source/eeprom_pkg.sv
package eeprom_pkg;

    typedef logic [10:0] mem_addr_t;   // 2048 byte array
    typedef logic [7:0]  mem_data_t;
    typedef logic [3:0]  bit_idx_t;    // slot within a byte, 0..8
    typedef logic [1:0]  phase_t;      // quarter of an SCL period

    localparam logic [3:0] DEVICE_TYPE = 4'b1010;

    // bus timing in CLK cycles
    localparam int QUARTER_CYCLES = 2;
    localparam int SLOT_CYCLES    = 4 * QUARTER_CYCLES;

    typedef logic [$clog2(QUARTER_CYCLES + 1) - 1:0] quarter_cnt_t;

    localparam quarter_cnt_t QUARTER_LAST = quarter_cnt_t'(QUARTER_CYCLES - 1);
    localparam phase_t       PHASE_LAST   = 2'd3;
    localparam bit_idx_t     ACK_SLOT     = 4'd8;   // ninth slot carries the acknowledge

    typedef enum logic [1:0] {
        slot_start,
        slot_stop,
        slot_data
    } slot_kind_e;

    typedef struct packed {
        slot_kind_e kind;
        logic       go;
    } slot_req_t;

    typedef struct packed {
        logic      load;
        mem_data_t load_byte;
        logic      receive;     // byte comes from the slave
        logic      master_ack;  // level sent in the ninth slot of a received byte
    } shift_cmd_t;

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_ctrl_w,
        st_addr,
        st_data_w,
        st_restart,
        st_ctrl_r,
        st_data_r,
        st_stop,
        st_done
    } ctrl_state_e;

endpackage

//--- source/eeprom_rw_top.sv
module eeprom_rw_top (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  eeprom_pkg::mem_addr_t addr,
    input  eeprom_pkg::mem_data_t data_in,
    output logic                  done,
    output logic                  nack,
    output eeprom_pkg::mem_data_t data_out,
    output logic                  scl,
    inout  wire                   sda
);

    eeprom_pkg::slot_req_t  slot_req;
    eeprom_pkg::shift_cmd_t shift_cmd;
    eeprom_pkg::mem_data_t  rx_byte;
    logic                   data_kind;
    logic                   slot_done;
    logic                   sample_bit;
    logic                   tx_bit;
    logic                   byte_done;
    logic                   ack_bit;

    eeprom_ctrl u_ctrl (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .data_in   (data_in),
        .slot_done (slot_done),
        .byte_done (byte_done),
        .ack_bit   (ack_bit),
        .rx_byte   (rx_byte),
        .slot_req  (slot_req),
        .shift_cmd (shift_cmd),
        .data_kind (data_kind),
        .done      (done),
        .nack      (nack),
        .data_out  (data_out)
    );

    byte_shifter u_shifter (
        .CLK        (CLK),
        .RESET      (RESET),
        .shift_cmd  (shift_cmd),
        .data_kind  (data_kind),
        .slot_done  (slot_done),
        .sample_bit (sample_bit),
        .tx_bit     (tx_bit),
        .byte_done  (byte_done),
        .ack_bit    (ack_bit),
        .rx_byte    (rx_byte)
    );

    bit_slot_gen u_slot_gen (
        .CLK        (CLK),
        .RESET      (RESET),
        .slot_req   (slot_req),
        .tx_bit     (tx_bit),
        .slot_done  (slot_done),
        .sample_bit (sample_bit),
        .scl        (scl),
        .sda        (sda)
    );

endmodule

//--- test/eeprom_checker.sv
module eeprom_checker (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  eeprom_pkg::mem_addr_t addr,
    input  eeprom_pkg::mem_data_t data_in,
    input  logic                  done,
    input  logic                  nack,
    input  eeprom_pkg::mem_data_t data_out,
    input  logic                  scl,
    input  wire                   sda,
    input  logic [127:0]          test_name,
    input  logic                  inject,
    input  eeprom_pkg::mem_data_t exp_data,
    input  logic                  exp_valid,
    output int                    err_total
);

    timeunit 1ns;
    timeprecision 1ps;

    eeprom_pkg::mem_data_t shadow [0:2047];
    eeprom_pkg::mem_addr_t addr_q;
    eeprom_pkg::mem_data_t data_q;
    eeprom_pkg::mem_data_t exp_q;
    eeprom_pkg::mem_data_t last_rd = '0;   // data_out holds the last good read
    logic [127:0]          name_q;
    logic                  busy = 1'b0;
    logic                  started = 1'b0;
    logic                  is_wr;
    logic                  inject_q;
    logic                  exp_valid_q;
    int                    data_errs = 0;
    int                    nack_errs = 0;
    int                    bus_errs = 0;
    int                    n_done = 0;

    assign err_total = data_errs + nack_errs + bus_errs;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            shadow[i] = i[7:0] ^ 8'h5a;
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    = 1'b0;
            started = 1'b0;
            last_rd = '0;
        end
        else
        begin
            if (!started && (done || nack || scl !== 1'b1 || sda !== 1'b1))
            begin
                bus_errs++;
                $display("bus not idle after reset before the first request");
            end
            if (done)
            begin
                n_done++;
                if (!busy)
                begin
                    bus_errs++;
                    $display("done pulsed with no request pending");
                end
                else if (nack !== inject_q)
                begin
                    nack_errs++;
                    $display("error %0s nack expected %0b actual %0b", name_q, inject_q, nack);
                end
                else if (!is_wr && !nack)
                begin
                    if (data_out !== shadow[addr_q])
                    begin
                        data_errs++;
                        $display("error %0s data expected %02h actual %02h",
                                 name_q, shadow[addr_q], data_out);
                    end
                    if (exp_valid_q && data_out !== exp_q)
                    begin
                        data_errs++;
                        $display("error %0s file data expected %02h actual %02h",
                                 name_q, exp_q, data_out);
                    end
                end
                else if (data_out !== last_rd)
                begin
                    data_errs++;
                    $display("error %0s held data expected %02h actual %02h",
                             name_q, last_rd, data_out);
                end
                if (busy && is_wr && !inject_q)
                    shadow[addr_q] = data_q;   // write went through
                if (busy && !is_wr && !inject_q)
                    last_rd = shadow[addr_q];
                busy = 1'b0;
            end
            else if (!busy && (wr || rd))
            begin
                busy        = 1'b1;
                started     = 1'b1;
                is_wr       = wr;   // wr wins
                addr_q      = addr;
                data_q      = data_in;
                name_q      = test_name;
                inject_q    = inject;
                exp_q       = exp_data;
                exp_valid_q = exp_valid;
            end
        end
    end

    task automatic report();
        $display("errors: data %0d nack %0d bus %0d, %0d operations done",
                 data_errs, nack_errs, bus_errs, n_done);
    endtask

endmodule

//--- test/eeprom_input.txt
# name op addr data inject
# op W write, R read with data as expected byte, B write with stray pulses, X random pairs
wr_basic   W 010 a5 0
rd_basic   R 010 a5 0
rd_fresh   R 123 79 0
rd_top     R 7ff a5 0
wr_high    W 5c3 3c 0
rd_high    R 5c3 3c 0
wr_nack    W 044 ee 1
rd_after   R 044 1e 0
rd_nack    R 200 00 1
wr_busy    B 300 77 0
rd_busy    R 300 77 0
rd_stray1  R 301 5b 0
rd_stray2  R 302 58 0
random     X 000 14 0

//--- test/eeprom_model.sv
module eeprom_model (
    input  logic scl,
    inout  wire  sda,
    input  logic nack_addr   // refuse the address byte
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int M_IDLE  = 0;
    localparam int M_CTRL  = 1;
    localparam int M_ADDR  = 2;
    localparam int M_WDATA = 3;
    localparam int M_RDATA = 4;

    eeprom_pkg::mem_data_t mem [0:2047];
    eeprom_pkg::mem_addr_t ptr;
    eeprom_pkg::mem_data_t sreg;
    eeprom_pkg::mem_data_t out_byte;
    int                    mode = M_IDLE;
    int                    next_mode = M_IDLE;
    int                    bcnt = 0;
    logic                  ack_phase = 1'b0;
    logic                  drive_low = 1'b0;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = i[7:0] ^ 8'h5a;
    end

    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            mode      = M_CTRL;   // start or repeated start
            bcnt      = 0;
            ack_phase = 1'b0;
            drive_low = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            mode      = M_IDLE;   // stop
            ack_phase = 1'b0;
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (mode != M_IDLE && bcnt < 8)
        begin
            if (mode != M_RDATA)
                sreg = {sreg[6:0], sda};
            bcnt = bcnt + 1;
        end
    end

    always @(negedge scl)
    begin
        if (mode == M_IDLE)
            drive_low = 1'b0;
        else if (ack_phase)
        begin
            ack_phase = 1'b0;
            bcnt      = 0;
            mode      = next_mode;
            drive_low = (mode == M_RDATA) ? ~out_byte[7] : 1'b0;
        end
        else if (bcnt == 8 && mode == M_RDATA)
        begin
            drive_low = 1'b0;       // master answers in the ninth slot
            next_mode = M_IDLE;
            ack_phase = 1'b1;
        end
        else if (bcnt == 8)
        begin
            drive_low = 1'b1;
            case (mode)
                M_CTRL:
                begin
                    if (sreg[7:4] != eeprom_pkg::DEVICE_TYPE)
                        drive_low = 1'b0;
                    ptr[10:8] = sreg[3:1];
                    out_byte  = mem[ptr];
                    next_mode = sreg[0] ? M_RDATA : M_ADDR;
                end
                M_ADDR:
                begin
                    ptr[7:0]  = sreg;
                    drive_low = ~nack_addr;
                    next_mode = M_WDATA;
                end
                default:
                begin
                    mem[ptr]  = sreg;
                    next_mode = M_WDATA;
                end
            endcase
            if (!drive_low)
                next_mode = M_IDLE;
            ack_phase = 1'b1;
        end
        else if (mode == M_RDATA)
            drive_low = ~out_byte[7 - bcnt];
    end

endmodule

//--- test/eeprom_props.sv
module eeprom_props (
    input logic                   CLK,
    input logic                   RESET,
    input logic                   scl,
    input wire                    sda,
    input logic                   active,
    input logic                   ctrl_idle,
    input eeprom_pkg::slot_kind_e kind,
    input logic                   done,
    input logic                   nack
);

    timeunit 1ns;
    timeprecision 1ps;

    // only start and stop slots may move sda under a high scl
    sda_stable_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !(active && kind != eeprom_pkg::slot_data)) |-> $stable(sda))
        else $error("sda moved while scl was high outside a start or stop slot");

    done_one_cycle: assert property (@(posedge CLK) disable iff (RESET) done |=> !done)
        else $error("done held for more than one cycle");

    nack_with_done: assert property (@(posedge CLK) disable iff (RESET) nack |-> done)
        else $error("nack raised without done");

    // no transaction running, bus rests with scl high
    scl_idle_high: assert property (@(posedge CLK) disable iff (RESET)
        ctrl_idle |-> scl)
        else $error("scl low while no transaction is running");

endmodule

//--- test/tb_eeprom_rw.sv
module tb_eeprom_rw;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int GAP = 20;   // idle cycles between operations

    logic                  CLK;
    logic                  RESET;
    logic                  wr;
    logic                  rd;
    eeprom_pkg::mem_addr_t addr;
    eeprom_pkg::mem_data_t data_in;
    logic                  done;
    logic                  nack;
    eeprom_pkg::mem_data_t data_out;
    logic                  scl;
    wire                   sda;
    logic [127:0]          test_name;
    logic                  inject;
    eeprom_pkg::mem_data_t exp_data;
    logic                  exp_valid;
    int                    err_total;
    logic                  ops_ready = 1'b0;
    int                    n_ops = 0;
    integer                seed = 32'hfdffee26;

    logic [127:0]          names [$];
    logic [7:0]            ops [$];
    eeprom_pkg::mem_addr_t addrs [$];
    eeprom_pkg::mem_data_t datas [$];
    logic                  injs [$];

    pullup (sda);

    eeprom_rw_top DUT (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .data_in  (data_in),
        .done     (done),
        .nack     (nack),
        .data_out (data_out),
        .scl      (scl),
        .sda      (sda)
    );

    eeprom_model slave (
        .scl       (scl),
        .sda       (sda),
        .nack_addr (inject)
    );

    eeprom_checker chk (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .data_in   (data_in),
        .done      (done),
        .nack      (nack),
        .data_out  (data_out),
        .scl       (scl),
        .sda       (sda),
        .test_name (test_name),
        .inject    (inject),
        .exp_data  (exp_data),
        .exp_valid (exp_valid),
        .err_total (err_total)
    );

    bind eeprom_rw_top eeprom_props u_props (
        .CLK       (CLK),
        .RESET     (RESET),
        .scl       (scl),
        .sda       (sda),
        .active    (u_slot_gen.active),
        .ctrl_idle (u_ctrl.state == eeprom_pkg::st_idle),
        .kind      (u_slot_gen.kind_q),
        .done      (done),
        .nack      (nack)
    );

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic pulse(input logic is_wr, input eeprom_pkg::mem_addr_t a,
                         input eeprom_pkg::mem_data_t d);
        @(negedge CLK);
        wr      = is_wr;
        rd      = ~is_wr;
        addr    = a;
        data_in = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_done();
        @(posedge CLK);
        while (done !== 1'b1)
            @(posedge CLK);
        repeat (GAP) @(negedge CLK);
    endtask

    task automatic single_op(input logic [127:0] nm, input logic is_wr,
                             input eeprom_pkg::mem_addr_t a, input eeprom_pkg::mem_data_t d,
                             input logic inj, input logic check_file);
        @(negedge CLK);
        test_name = nm;
        inject    = inj;
        exp_data  = d;
        exp_valid = ~is_wr & check_file;
        pulse(is_wr, a, d);
        wait_done();
    endtask

    // write with stray requests that land while the bus is busy
    task automatic busy_write(input logic [127:0] nm, input eeprom_pkg::mem_addr_t a,
                              input eeprom_pkg::mem_data_t d);
        @(negedge CLK);
        test_name = nm;
        inject    = 1'b0;
        exp_valid = 1'b0;
        pulse(1'b1, a, d);
        repeat (30) @(negedge CLK);
        pulse(1'b1, a + 11'd1, ~d);
        repeat (40) @(negedge CLK);
        pulse(1'b0, a + 11'd2, d);
        wait_done();
    endtask

    task automatic random_pairs(input logic [127:0] nm, input int count);
        eeprom_pkg::mem_addr_t a;
        eeprom_pkg::mem_data_t d;
        for (int i = 0; i < count; i++)
        begin
            a = $random(seed);
            d = $random(seed);
            single_op(nm, 1'b1, a, d, 1'b0, 1'b0);
            single_op(nm, 1'b0, a, d, 1'b0, 1'b0);
        end
    endtask

    initial
    begin
        wait (ops_ready);
        #(n_ops * 50 * eeprom_pkg::SLOT_CYCLES * 8);
        $display("timed out waiting for done after %0d operations", n_ops);
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        int           fd;
        logic [799:0] line;
        logic [127:0] nm;
        logic [7:0]   op;
        logic [31:0]  a;
        logic [31:0]  d;
        logic [31:0]  inj;
        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        data_in   = '0;
        inject    = 1'b0;
        exp_data  = '0;
        exp_valid = 1'b0;
        test_name = "reset";
        fd = $fopen("test/eeprom_input.txt", "r");
        if (fd == 0)
        begin
            $display("could not open test/eeprom_input.txt");
            $display("** FAIL **");
            $finish;
        end
        else
        begin
            while ($fgets(line, fd))
            begin
                if ($sscanf(line, "%s %s %h %h %d", nm, op, a, d, inj) == 5 && nm != "#")
                begin
                    names.push_back(nm);
                    ops.push_back(op);
                    addrs.push_back(a[10:0]);
                    datas.push_back(d[7:0]);
                    injs.push_back(inj[0]);
                    n_ops += (op == "X") ? 2 * d : 1;
                end
            end
            $fclose(fd);
            ops_ready = 1'b1;
            repeat (4) @(posedge CLK);
            @(negedge CLK);
            RESET = 1'b0;
            repeat (GAP) @(negedge CLK);   // idle bus is checked here
            foreach (ops[i])
            begin
                if (ops[i] == "W")
                    single_op(names[i], 1'b1, addrs[i], datas[i], injs[i], 1'b1);
                else if (ops[i] == "R")
                    single_op(names[i], 1'b0, addrs[i], datas[i], injs[i], 1'b1);
                else if (ops[i] == "B")
                    busy_write(names[i], addrs[i], datas[i]);
                else
                    random_pairs(names[i], datas[i]);
            end
            chk.report();
            if (err_total == 0)
                $display("** PASS **");
            else
                $display("** FAIL **");
            $finish;
        end
    end

endmodule

//--- verilog.f
source/eeprom_pkg.sv
source/eeprom_ctrl.sv
source/byte_shifter.sv
source/bit_slot_gen.sv
source/eeprom_rw_top.sv
test/eeprom_props.sv
test/eeprom_model.sv
test/eeprom_checker.sv
test/tb_eeprom_rw.sv
